/* muldiv_defines.svh */
/*
 * Fixed parameters of the RV32M multiply/divide unit.
 * Include this wherever the data width, the divide step count or a funct3 code is needed.
 */
`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

`define MULDIV_XLEN       32  // operand and result width
`define MULDIV_DIV_STEPS  32  // one quotient bit per step

// ------------------------------------------------------------
// funct3 codes of the M extension
// ------------------------------------------------------------
`define MULDIV_F3_MUL     3'd0
`define MULDIV_F3_MULH    3'd1
`define MULDIV_F3_MULHSU  3'd2
`define MULDIV_F3_MULHU   3'd3
`define MULDIV_F3_DIV     3'd4
`define MULDIV_F3_DIVU    3'd5
`define MULDIV_F3_REM     3'd6
`define MULDIV_F3_REMU    3'd7

`endif

/* muldiv_pkg.sv */
/*
 * Types shared by the multiply/divide unit and its testbench.
 * Refer to them by scoped name, e.g. muldiv_pkg::word_t.
 */
`include "muldiv_defines.svh"

package muldiv_pkg;

    // ------------------------------------------------------------
    // data vectors
    // ------------------------------------------------------------
    typedef logic [`MULDIV_XLEN-1:0]   word_t;   // one operand or result
    typedef logic [2*`MULDIV_XLEN-1:0] dword_t;  // full product
    typedef logic [2:0]                funct3_t; // operation select

    typedef logic [$clog2(`MULDIV_DIV_STEPS)-1:0] step_cnt_t;  // divide iterations left

    // ------------------------------------------------------------
    // state machines
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_CHECK,  // divisor test and magnitudes
        DIV_EXEC,   // shift-subtract steps
        DIV_RET     // result on the output
    } div_state_t;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_EXEC,
        MUL_RET
    } mul_state_t;

endpackage

/* div_step_counter.sv */
/*
 * Down-counter of divider iterations.
 * Loaded with the step count minus one in the check state and stepped once
 * per execute cycle; last_o marks the final iteration.
 */
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module div_step_counter (
    input  logic clk_i,
    input  logic rst_i,
    input  logic load_i,
    input  logic step_i,
    output logic last_o
);

    muldiv_pkg::step_cnt_t count_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= muldiv_pkg::step_cnt_t'(`MULDIV_DIV_STEPS - 1);  // 31 for RV32
        end else if (step_i) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign last_o = (count_q == '0);  // final shift-subtract step

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    // the FSM must stop stepping once the last iteration is reached
    a_no_step_at_zero : assert property (
        @(posedge clk_i) disable iff (rst_i)
        step_i |-> (count_q != '0)
    ) else $error("divider step requested with a zero count");

endmodule

/* div_fsm.sv */
/*
 * Control FSM of the restoring divider.
 * Starts on a valid divide code, takes the short path for a zero divisor,
 * sequences the step counter and drives the stall level.
 */
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module div_fsm (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   valid_i,
    input  muldiv_pkg::funct3_t    funct3_i,
    input  logic                   divisor_zero_i,
    input  logic                   last_step_i,
    output logic                   start_o,
    output logic                   cnt_load_o,
    output logic                   cnt_step_o,
    output logic                   stall_o,
    output muldiv_pkg::div_state_t state_o
);

    muldiv_pkg::div_state_t state_q;
    muldiv_pkg::div_state_t state_d;
    logic                   is_div_code;

    assign is_div_code = (funct3_i == `MULDIV_F3_DIV) || (funct3_i == `MULDIV_F3_DIVU) ||
                         (funct3_i == `MULDIV_F3_REM) || (funct3_i == `MULDIV_F3_REMU);

    assign start_o = (state_q == muldiv_pkg::DIV_IDLE) && valid_i && is_div_code;

    always_comb begin
        state_d = state_q;
        case (state_q)
            muldiv_pkg::DIV_IDLE: begin
                if (start_o) begin
                    state_d = muldiv_pkg::DIV_CHECK;
                end
            end
            muldiv_pkg::DIV_CHECK: begin
                state_d = divisor_zero_i ? muldiv_pkg::DIV_RET : muldiv_pkg::DIV_EXEC;
            end
            muldiv_pkg::DIV_EXEC: begin
                if (last_step_i) begin
                    state_d = muldiv_pkg::DIV_RET;
                end
            end
            default: begin
                state_d = muldiv_pkg::DIV_IDLE;  // return lasts one cycle
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= muldiv_pkg::DIV_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign cnt_load_o = (state_q == muldiv_pkg::DIV_CHECK);
    assign cnt_step_o = (state_q == muldiv_pkg::DIV_EXEC) && !last_step_i;
    assign stall_o    = (state_d != muldiv_pkg::DIV_IDLE);  // low again in the return cycle
    assign state_o    = state_q;

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    // full iteration count from check to return across counter and FSM
    a_div_latency : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (state_q == muldiv_pkg::DIV_CHECK && !divisor_zero_i)
            |-> ##(`MULDIV_DIV_STEPS + 1) (state_q == muldiv_pkg::DIV_RET)
    ) else $error("divider return not reached after the full step count");

endmodule

/* div_datapath.sv */
/*
 * Datapath of the restoring divider.
 * Holds the divisor, the partial remainder and the quotient, makes operands
 * unsigned before the iterations and fixes the signs on the way out.
 * rslt_o is zero outside the return state so results can be ORed.
 */
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module div_datapath (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   start_i,
    input  muldiv_pkg::div_state_t state_i,
    input  muldiv_pkg::funct3_t    funct3_i,
    input  muldiv_pkg::word_t      src1_i,
    input  muldiv_pkg::word_t      src2_i,
    output logic                   divisor_zero_o,
    output muldiv_pkg::word_t      rslt_o
);

    // ------------------------------------------------------------
    // operation decode
    // ------------------------------------------------------------
    logic is_signed;
    logic is_rem_op;

    assign is_signed = (funct3_i == `MULDIV_F3_DIV) || (funct3_i == `MULDIV_F3_REM);
    assign is_rem_op = (funct3_i == `MULDIV_F3_REM) || (funct3_i == `MULDIV_F3_REMU);

    // sign and select flags
    logic is_rem_q;
    logic dividend_neg_q;
    logic divisor_neg_q;
    logic quot_neg_q;
    logic rem_neg_q;

    // working registers
    muldiv_pkg::word_t divisor_q;
    muldiv_pkg::word_t remainder_q;
    muldiv_pkg::word_t quotient_q;

    logic in_check;
    logic in_exec;

    assign in_check = (state_i == muldiv_pkg::DIV_CHECK);
    assign in_exec  = (state_i == muldiv_pkg::DIV_EXEC);

    assign divisor_zero_o = (divisor_q == '0);  // only meaningful in check

    // ------------------------------------------------------------
    // magnitudes and one restoring step
    // ------------------------------------------------------------
    muldiv_pkg::word_t      dividend_mag;
    muldiv_pkg::word_t      divisor_mag;
    logic [`MULDIV_XLEN:0]   shifted;   // keeps the remainder msb
    logic [`MULDIV_XLEN+1:0] diff;
    logic                   quot_bit;

    assign dividend_mag = dividend_neg_q ? -remainder_q : remainder_q;
    assign divisor_mag  = divisor_neg_q ? -divisor_q : divisor_q;

    assign shifted  = {remainder_q, quotient_q[`MULDIV_XLEN-1]};
    assign diff     = {1'b0, shifted} - {2'b00, divisor_q};
    assign quot_bit = !diff[`MULDIV_XLEN+1];  // no borrow means the subtraction sticks

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            is_rem_q       <= 1'b0;
            dividend_neg_q <= 1'b0;
            divisor_neg_q  <= 1'b0;
            quot_neg_q     <= 1'b0;
            rem_neg_q      <= 1'b0;
        end else if (start_i) begin
            is_rem_q       <= is_rem_op;
            dividend_neg_q <= is_signed && src1_i[`MULDIV_XLEN-1];
            divisor_neg_q  <= is_signed && src2_i[`MULDIV_XLEN-1];
            quot_neg_q     <= is_signed && (src1_i[`MULDIV_XLEN-1] ^ src2_i[`MULDIV_XLEN-1]);
            rem_neg_q      <= is_signed && src1_i[`MULDIV_XLEN-1];  // follows the dividend
        end else if (in_check && divisor_zero_o) begin
            quot_neg_q     <= 1'b0;  // raw all ones and dividend
            rem_neg_q      <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            divisor_q   <= src2_i;
            remainder_q <= src1_i;  // dividend parked here until check
            quotient_q  <= '0;
        end else if (in_check) begin
            if (divisor_zero_o) begin
                quotient_q  <= '1;
            end else begin
                divisor_q   <= divisor_mag;
                remainder_q <= '0;
                quotient_q  <= dividend_mag;  // shifted out msb first
            end
        end else if (in_exec) begin
            remainder_q <= quot_bit ? diff[`MULDIV_XLEN-1:0] : shifted[`MULDIV_XLEN-1:0];
            quotient_q  <= {quotient_q[`MULDIV_XLEN-2:0], quot_bit};
        end
    end

    // ------------------------------------------------------------
    // result
    // ------------------------------------------------------------
    muldiv_pkg::word_t quot_fixed;
    muldiv_pkg::word_t rem_fixed;

    assign quot_fixed = quot_neg_q ? -quotient_q : quotient_q;
    assign rem_fixed  = rem_neg_q ? -remainder_q : remainder_q;

    assign rslt_o = (state_i != muldiv_pkg::DIV_RET) ? '0 :
                    (is_rem_q ? rem_fixed : quot_fixed);

    // a zero divisor must take the short path and never iterate
    a_exec_divisor_nonzero : assert property (
        @(posedge clk_i) disable iff (rst_i)
        in_exec |-> (divisor_q != '0)
    ) else $error("divider iterating with a zero divisor");

endmodule

/* multiplier.sv */
/*
 * Two-stage RV32M multiplier.
 * Captures 33-bit sign-extended operands on issue, registers the signed
 * product one cycle later and presents the selected half in the return state.
 */
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module multiplier (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                valid_i,
    input  muldiv_pkg::funct3_t funct3_i,
    input  muldiv_pkg::word_t   src1_i,
    input  muldiv_pkg::word_t   src2_i,
    output logic                stall_o,
    output muldiv_pkg::word_t   rslt_o
);

    muldiv_pkg::mul_state_t state_q;
    muldiv_pkg::mul_state_t state_d;

    logic is_mul_code;
    logic src1_signed;
    logic src2_signed;
    logic start;

    assign is_mul_code = (funct3_i == `MULDIV_F3_MUL)    || (funct3_i == `MULDIV_F3_MULH) ||
                         (funct3_i == `MULDIV_F3_MULHSU) || (funct3_i == `MULDIV_F3_MULHU);
    assign src1_signed = (funct3_i == `MULDIV_F3_MULH) || (funct3_i == `MULDIV_F3_MULHSU);
    assign src2_signed = (funct3_i == `MULDIV_F3_MULH);

    assign start = (state_q == muldiv_pkg::MUL_IDLE) && valid_i && is_mul_code;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    always_comb begin
        case (state_q)
            muldiv_pkg::MUL_IDLE: state_d = start ? muldiv_pkg::MUL_EXEC : muldiv_pkg::MUL_IDLE;
            muldiv_pkg::MUL_EXEC: state_d = muldiv_pkg::MUL_RET;
            default:              state_d = muldiv_pkg::MUL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= muldiv_pkg::MUL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign stall_o = (state_d != muldiv_pkg::MUL_IDLE);

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------
    logic signed [`MULDIV_XLEN:0]     op_a_q;  // 33-bit operands
    logic signed [`MULDIV_XLEN:0]     op_b_q;
    logic signed [2*`MULDIV_XLEN+1:0] full_product;
    muldiv_pkg::dword_t               product_q;
    logic                             high_q;

    assign full_product = op_a_q * op_b_q;

    always_ff @(posedge clk_i) begin
        if (start) begin
            op_a_q <= {src1_signed && src1_i[`MULDIV_XLEN-1], src1_i};
            op_b_q <= {src2_signed && src2_i[`MULDIV_XLEN-1], src2_i};
            high_q <= (funct3_i != `MULDIV_F3_MUL);  // all but MUL take the upper word
        end
        if (state_q == muldiv_pkg::MUL_EXEC) begin
            product_q <= full_product[2*`MULDIV_XLEN-1:0];
        end
    end

    assign rslt_o = (state_q != muldiv_pkg::MUL_RET) ? '0 :
                    (high_q ? product_q[2*`MULDIV_XLEN-1:`MULDIV_XLEN]
                            : product_q[`MULDIV_XLEN-1:0]);

endmodule

/* muldiv.sv */
/*
 * RV32M execution unit: multiplier and restoring divider side by side.
 * Issue with a one-cycle valid_i pulse; hold off while stall_o is high.
 * The result is valid in the cycle where stall_o drops, zero otherwise.
 */
`timescale 1ns/1ps

module muldiv (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                valid_i,
    input  muldiv_pkg::funct3_t funct3_i,
    input  muldiv_pkg::word_t   src1_i,
    input  muldiv_pkg::word_t   src2_i,
    output logic                stall_o,
    output muldiv_pkg::word_t   rslt_o
);

    logic                   mul_stall;
    muldiv_pkg::word_t      mul_rslt;
    logic                   div_stall;
    muldiv_pkg::word_t      div_rslt;
    logic                   div_start;
    logic                   cnt_load;
    logic                   cnt_step;
    logic                   last_step;
    logic                   divisor_zero;
    muldiv_pkg::div_state_t div_state;

    // ------------------------------------------------------------
    // multiplier, funct3 0 to 3
    // ------------------------------------------------------------
    multiplier u_multiplier (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .valid_i  (valid_i),
        .funct3_i (funct3_i),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .stall_o  (mul_stall),
        .rslt_o   (mul_rslt)
    );

    // ------------------------------------------------------------
    // divider, funct3 4 to 7
    // ------------------------------------------------------------
    div_fsm u_div_fsm (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .valid_i        (valid_i),
        .funct3_i       (funct3_i),
        .divisor_zero_i (divisor_zero),
        .last_step_i    (last_step),
        .start_o        (div_start),
        .cnt_load_o     (cnt_load),
        .cnt_step_o     (cnt_step),
        .stall_o        (div_stall),
        .state_o        (div_state)
    );

    div_step_counter u_div_step_counter (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .load_i (cnt_load),
        .step_i (cnt_step),
        .last_o (last_step)
    );

    div_datapath u_div_datapath (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .start_i        (div_start),
        .state_i        (div_state),
        .funct3_i       (funct3_i),
        .src1_i         (src1_i),
        .src2_i         (src2_i),
        .divisor_zero_o (divisor_zero),
        .rslt_o         (div_rslt)
    );

    assign stall_o = mul_stall | div_stall;
    assign rslt_o  = mul_rslt | div_rslt;  // idle unit drives zero

endmodule

/* tb_muldiv.sv */
/*
 * Self-checking testbench of the RV32M multiply/divide unit.
 * Drives random and corner operations from an LFSR and compares every result
 * and its latency with a reference model, then prints a summary.
 */
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module tb_muldiv;

    localparam int          RESET_CYCLES = 16;
    localparam int          DRIVE_DELAY  = 1;    // ns after the rising edge
    localparam int          OP_TIMEOUT   = 100;  // cycles, beyond any latency
    localparam int          RANDOM_OPS   = 100;
    localparam logic [31:0] LFSR_SEED    = 32'hda71_53e0;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

    logic                clk_i;
    logic                rst_i;
    logic                valid_i;
    muldiv_pkg::funct3_t funct3_i;
    muldiv_pkg::word_t   src1_i;
    muldiv_pkg::word_t   src2_i;
    logic                stall_o;
    muldiv_pkg::word_t   rslt_o;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          tests;
    int          ops;
    int          err_mark;  // counts at the start of the current test
    int          ops_mark;

    muldiv dut (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .valid_i  (valid_i),
        .funct3_i (funct3_i),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .stall_o  (stall_o),
        .rslt_o   (rslt_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;  // 4 ns period
    end

    // ------------------------------------------------------------
    // stimulus source and reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
        end
        return value;
    endfunction

    function automatic muldiv_pkg::word_t model_result(input muldiv_pkg::funct3_t f3,
                                                       input muldiv_pkg::word_t   a,
                                                       input muldiv_pkg::word_t   b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ua;
        logic signed [63:0] ub;
        logic signed [63:0] wide;
        logic               overflow;
        sa       = {{32{a[31]}}, a};
        sb       = {{32{b[31]}}, b};
        ua       = {32'd0, a};
        ub       = {32'd0, b};
        overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        wide     = '0;
        case (f3)
            `MULDIV_F3_MUL:    wide = sa * sb;
            `MULDIV_F3_MULH:   wide = (sa * sb) >>> 32;
            `MULDIV_F3_MULHSU: wide = (sa * ub) >>> 32;
            `MULDIV_F3_MULHU:  wide = (ua * ub) >> 32;
            `MULDIV_F3_DIV:    wide = (b == '0) ? -64'sd1 : (overflow ? sa : sa / sb);
            `MULDIV_F3_DIVU:   wide = (b == '0) ? -64'sd1 : ua / ub;
            `MULDIV_F3_REM:    wide = (b == '0) ? sa : (overflow ? 64'sd0 : sa % sb);
            default:           wide = (b == '0) ? ua : ua % ub;  // REMU
        endcase
        return wide[31:0];
    endfunction

    function automatic int op_latency(input muldiv_pkg::funct3_t f3,
                                      input muldiv_pkg::word_t   divisor);
        if (!f3[2] || divisor == '0) begin
            return 2;  // multiply, or divide by zero short path
        end else begin
            return `MULDIV_DIV_STEPS + 2;  // check, steps, return
        end
    endfunction

    // ------------------------------------------------------------
    // checking and reporting
    // ------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("TIMEOUT t=%0t: %s within %0d cycles", $time, what, OP_TIMEOUT);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %0d ops, %0d errors", tests, name, ops - ops_mark,
                 errors - err_mark);
        err_mark = errors;
        ops_mark = ops;
    endtask

    // ------------------------------------------------------------
    // operation driver
    // ------------------------------------------------------------
    task automatic random_op(input logic is_div, output muldiv_pkg::funct3_t f3,
                             output muldiv_pkg::word_t a, output muldiv_pkg::word_t b);
        logic [31:0] code;
        logic [31:0] shift;
        code = take_bits(2);
        f3   = {is_div, code[1:0]};
        a    = take_bits(32);
        b    = take_bits(32);
        if (is_div) begin
            shift = take_bits(5);
            b     = $signed(b) >>> shift[4:0];  // spread divisor magnitudes
            if (b == '0) begin
                b = 32'd1;
            end
        end
    endtask

    // starts and ends 1 ns after a rising edge with the unit idle
    task automatic run_op(input muldiv_pkg::funct3_t f3, input muldiv_pkg::word_t a,
                          input muldiv_pkg::word_t b, input int extra_at,
                          input muldiv_pkg::funct3_t extra_f3);
        muldiv_pkg::word_t expected;
        int                latency;
        int                cycle;
        logic              returned;
        expected = model_result(f3, a, b);
        latency  = op_latency(f3, b);
        valid_i  = 1'b1;
        funct3_i = f3;
        src1_i   = a;
        src2_i   = b;
        @(negedge clk_i);
        check_value("stall_o", 32'd1, {31'd0, stall_o});  // busy from the issue cycle
        check_value("rslt_o", '0, rslt_o);
        cycle    = 0;
        returned = 1'b0;
        while (!returned && cycle < OP_TIMEOUT) begin
            @(posedge clk_i);
            #(DRIVE_DELAY);
            cycle++;
            valid_i  = (cycle == extra_at);  // pulse while busy
            funct3_i = (cycle == extra_at) ? extra_f3 : f3;
            src1_i   = ~a;  // unit works from its captured copy
            src2_i   = ~b;
            @(negedge clk_i);
            if (stall_o) begin
                check_value("rslt_o", '0, rslt_o);
            end else begin
                returned = 1'b1;
            end
        end
        if (returned) begin
            check_value("stall_o low cycle", latency, cycle);
            check_value("rslt_o", expected, rslt_o);
        end else begin
            report_timeout("operation did not return");
        end
        @(posedge clk_i);
        #(DRIVE_DELAY);
        valid_i = 1'b0;
        ops++;
    endtask

    task automatic check_quiet(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk_i);
            check_value("stall_o", '0, {31'd0, stall_o});
            check_value("rslt_o", '0, rslt_o);
            @(posedge clk_i);
            #(DRIVE_DELAY);
        end
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic random_ops(input logic is_div, input string name);
        muldiv_pkg::funct3_t f3;
        muldiv_pkg::word_t   a;
        muldiv_pkg::word_t   b;
        int                  i;
        for (i = 0; i < RANDOM_OPS; i++) begin
            random_op(is_div, f3, a, b);
            run_op(f3, a, b, 0, f3);
        end
        finish_test(name);
    endtask

    task automatic corner_operands();
        muldiv_pkg::word_t corners [7];
        int                fi;
        int                ai;
        int                bi;
        corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
                    32'hffff_fff9, 32'h3};
        for (fi = 0; fi < 8; fi++) begin
            for (ai = 0; ai < 7; ai++) begin
                for (bi = 0; bi < 7; bi++) begin
                    run_op(muldiv_pkg::funct3_t'(fi), corners[ai], corners[bi], 0, '0);
                end
            end
        end
        finish_test("corner operands");
    endtask

    task automatic busy_issue_ignored();
        muldiv_pkg::funct3_t f3;
        muldiv_pkg::word_t   a;
        muldiv_pkg::word_t   b;
        logic [31:0]         code;
        int                  i;
        for (i = 0; i < 4; i++) begin
            random_op(1'b1, f3, a, b);
            code = take_bits(2);
            run_op(f3, a, b, 3, {1'b1, code[1:0]});  // second divide mid execute
            check_quiet(`MULDIV_DIV_STEPS + 4);
            random_op(1'b0, f3, a, b);
            code = take_bits(2);
            run_op(f3, a, b, 1, {1'b0, code[1:0]});
            check_quiet(4);
        end
        finish_test("issue while busy");
    endtask

    task automatic reset_mid_division();
        muldiv_pkg::funct3_t f3;
        muldiv_pkg::word_t   a;
        muldiv_pkg::word_t   b;
        int                  i;
        random_op(1'b1, f3, a, b);
        valid_i  = 1'b1;
        funct3_i = f3;
        src1_i   = a;
        src2_i   = b;
        for (i = 0; i < 10; i++) begin
            @(posedge clk_i);
            #(DRIVE_DELAY);
            valid_i = 1'b0;
            @(negedge clk_i);
            check_value("stall_o", 32'd1, {31'd0, stall_o});
        end
        @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_i = 1'b1;
        @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_i = 1'b0;
        check_quiet(8);
        random_op(1'b1, f3, a, b);
        run_op(f3, a, b, 0, f3);
        random_op(1'b0, f3, a, b);
        run_op(f3, a, b, 0, f3);
        finish_test("reset during divide");
    endtask

    initial begin
        lfsr_state = LFSR_SEED;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        ops        = 0;
        err_mark   = 0;
        ops_mark   = 0;
        rst_i      = 1'b1;
        valid_i    = 1'b0;
        funct3_i   = '0;
        src1_i     = '0;
        src2_i     = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_i = 1'b0;

        check_quiet(8);
        finish_test("idle after reset");
        random_ops(1'b0, "random multiply");
        random_ops(1'b1, "random divide");
        corner_operands();
        busy_issue_ignored();
        reset_mid_division();

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* muldiv.f */
+incdir+.
muldiv_pkg.sv
div_step_counter.sv
div_fsm.sv
div_datapath.sv
multiplier.sv
muldiv.sv
tb_muldiv.sv

/* Makefile */
# Verilator flow for the muldiv testbench
# make        build and run, fails unless the pass message is printed
# make lint   lint only
# make clean  remove the build directory

VERILATOR ?= verilator
TOP       ?= tb_muldiv
BUILD_DIR ?= build
FILELIST  ?= muldiv.f
VFLAGS    ?= --assert
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
